//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv32_core_tb
FILELIST  ?= rv32_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/rv32_core_chk.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_core_chk (
  input logic               clk,
  input logic               reset,
  input rv32_pkg::mem_req_t mem_req,
  input rv32_pkg::mem_rsp_t mem_rsp,
  input logic               trap
);

  // request fields hold while memory stalls
  assert property (@(posedge clk) disable iff (reset)
    mem_req.valid && !mem_rsp.ready |=> mem_req.valid && $stable(mem_req.instr) &&
      $stable(mem_req.addr) && $stable(mem_req.wdata) && $stable(mem_req.wstrb))
    else $error("memory request changed while waiting for ready");

  assert property (@(posedge clk) disable iff (reset)
    mem_req.valid && mem_rsp.ready |=> !mem_req.valid)
    else $error("valid stayed high after the transfer");

  assert property (@(posedge clk) disable iff (reset)
    mem_req.valid && mem_req.instr |-> mem_req.wstrb == 4'b0000)
    else $error("fetch carries a write strobe");

  assert property (@(posedge clk) disable iff (reset) trap |=> trap)
    else $error("trap fell without reset");

  assert property (@(posedge clk) disable iff (reset) trap |-> !mem_req.valid)
    else $error("memory request while trapped");

endmodule

bind rv32_core rv32_core_chk i_chk (.*);

`default_nettype wire

//--- dv/rv32_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_core_tb;

  // about 5 tests x 120 instructions x 13 cycles, with margin
  localparam int max_cycles = 20000;
  localparam int result_idx = 512;
  localparam int data_idx   = 768;
  localparam int done_idx   = 1023;
  localparam logic [31:0] done_value = 32'h600d_cafe;

  logic               clk;
  logic               reset;
  rv32_pkg::mem_req_t mem_req;
  rv32_pkg::mem_rsp_t mem_rsp;
  logic               trap;

  logic [31:0] mem [1024];
  logic [31:0] expect_q [$];
  int          prog_idx;
  int unsigned max_wait;
  int unsigned wait_left;
  logic        busy;
  int          cycles;
  int          checks;
  int          errors;
  string       test_name;

  rv32_core #(
    .reset_pc(32'h0000_0000)
  ) i_dut (
    .clk    (clk),
    .reset  (reset),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp),
    .trap   (trap)
  );

  always #20 clk = ~clk;

  // memory responds on the falling edge after 0 to max_wait wait cycles
  always @(negedge clk) begin
    if (reset) begin
      mem_rsp.ready = 1'b0;
      busy = 1'b0;
    end else if (mem_rsp.ready) begin
      mem_rsp.ready = 1'b0;
    end else if (mem_req.valid) begin
      if (!busy) begin
        busy = 1'b1;
        wait_left = $urandom_range(max_wait, 0);
      end
      if (wait_left == 0) begin
        mem_rsp.ready = 1'b1;
        mem_rsp.rdata = mem[mem_req.addr[11:2]];
        busy = 1'b0;
      end else begin
        wait_left--;
      end
    end
  end

  // writes land on the edge that completes the transfer
  always @(posedge clk) begin
    if (!reset && mem_req.valid && mem_rsp.ready) begin
      for (int i = 0; i < 4; i++) begin
        if (mem_req.wstrb[i]) begin
          mem[mem_req.addr[11:2]][8*i +: 8] = mem_req.wdata[8*i +: 8];
        end
      end
      // programs sit below the result area, data accesses above it
      if (mem_req.instr !== (int'(mem_req.addr[11:2]) < result_idx)) begin
        errors++;
        $display("error: %s fetch flag at 0x%03h expected %b actual %b",
                 test_name, mem_req.addr[11:0], int'(mem_req.addr[11:2]) < result_idx,
                 mem_req.instr);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run exceeded %0d cycles with %0d errors", max_cycles, errors);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv32_pkg::opc_op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv32_pkg::opc_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv32_pkg::opc_branch};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opcode);
    return {imm, rd, opcode};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv32_pkg::opc_jal};
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return {6'h2b, 10'(idx), 6'h15, ~10'(idx)};
  endfunction

  // expected values from the RV32I instruction definitions
  function automatic logic [31:0] alu_expect(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] r;
    sh = b[4:0];
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << sh;
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> sh;
        end else begin
          r = a >> sh;
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_expect(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] load_expect(input logic [2:0] f3, input int off,
                                              input logic [31:0] w);
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    lane_b = w[8*off +: 8];
    lane_h = w[8*(off & 2) +: 16];
    case (f3)
      3'b000: return {{24{lane_b[7]}}, lane_b};
      3'b100: return {24'h0, lane_b};
      3'b001: return {{16{lane_h[15]}}, lane_h};
      3'b101: return {16'h0, lane_h};
      default: return w;
    endcase
  endfunction

  task automatic emit(input logic [31:0] word);
    mem[prog_idx] = word;
    prog_idx++;
  endtask

  task automatic load_imm(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = (value + 32'h800) >> 12;
    emit(u_type(upper[19:0], rd, rv32_pkg::opc_lui));
    emit(i_type(value[11:0], rd, 3'b000, rd, rv32_pkg::opc_op_imm));
  endtask

  // x1 points at the result area
  task automatic store_result(input logic [4:0] rs, input logic [31:0] expected);
    emit(s_type(12'(4 * expect_q.size()), rs, 5'd1, 3'b010));
    expect_q.push_back(expected);
  endtask

  task automatic begin_program(input string name);
    @(negedge clk);
    reset = 1'b1;
    test_name = name;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = fill_word(i);
    end
    prog_idx = 0;
    expect_q.delete();
    load_imm(5'd1, 32'h0000_0800);
  endtask

  task automatic end_program();
    load_imm(5'd31, done_value);
    emit(s_type(12'h7fc, 5'd31, 5'd1, 3'b010));
    emit(j_type(21'd0, 5'd0));
  endtask

  task automatic release_reset();
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic run_until_done(input string name);
    release_reset();
    while (mem[done_idx] !== done_value && !trap) begin
      @(negedge clk);
    end
    if (trap) begin
      errors++;
      $display("%s: core trapped before finishing its program", name);
    end
  endtask

  task automatic compare_word(input string name, input int idx, input logic [31:0] expected);
    checks++;
    if (mem[idx] !== expected) begin
      errors++;
      $display("error: %s at 0x%03h expected %08h actual %08h",
               name, idx * 4, expected, mem[idx]);
    end
  endtask

  task automatic compare_results(input string name);
    foreach (expect_q[k]) begin
      compare_word(name, result_idx + k, expect_q[k]);
    end
  endtask

  task automatic alu_ops_test(input string name, input int rounds);
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    logic [19:0] upper;
    logic [31:0] here;
    begin_program(name);
    repeat (rounds) begin
      a = $urandom();
      b = $urandom();
      load_imm(5'd2, a);
      load_imm(5'd3, b);
      for (int f3 = 0; f3 < 8; f3++) begin
        emit(r_type(7'h00, 5'd3, 5'd2, 3'(f3), 5'd4));
        store_result(5'd4, alu_expect(3'(f3), 1'b0, a, b));
        if (f3 == 0 || f3 == 5) begin
          emit(r_type(7'h20, 5'd3, 5'd2, 3'(f3), 5'd4));
          store_result(5'd4, alu_expect(3'(f3), 1'b1, a, b));
        end
      end
      for (int f3 = 0; f3 < 8; f3++) begin
        imm = (f3 == 1 || f3 == 5) ? {7'h00, 5'($urandom())} : 12'($urandom());
        emit(i_type(imm, 5'd2, 3'(f3), 5'd5, rv32_pkg::opc_op_imm));
        store_result(5'd5, alu_expect(3'(f3), 1'b0, a, {{20{imm[11]}}, imm}));
        if (f3 == 5) begin
          imm = {7'h20, 5'($urandom())};
          emit(i_type(imm, 5'd2, 3'd5, 5'd5, rv32_pkg::opc_op_imm));
          store_result(5'd5, alu_expect(3'd5, 1'b1, a, {20'h0, imm}));
        end
      end
      upper = 20'($urandom());
      emit(u_type(upper, 5'd6, rv32_pkg::opc_lui));
      store_result(5'd6, {upper, 12'h000});
      upper = 20'($urandom());
      here = 32'(prog_idx * 4);
      emit(u_type(upper, 5'd6, rv32_pkg::opc_auipc));
      store_result(5'd6, here + {upper, 12'h000});
      emit(r_type(7'h00, 5'd3, 5'd2, 3'd0, 5'd0));
      store_result(5'd0, 32'h0);
    end
    end_program();
    run_until_done(name);
    compare_results(name);
  endtask

  task automatic control_flow_test(input string name);
    logic [31:0] a;
    logic [31:0] n;
    logic [31:0] p;
    logic [31:0] va;
    logic [31:0] vb;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [31:0] here;
    begin_program(name);
    a = $urandom();
    n = $urandom() | 32'h8000_0000;
    p = $urandom() & 32'h7fff_ffff;
    load_imm(5'd7, a);
    load_imm(5'd8, n);
    load_imm(5'd9, p);
    for (int f3 = 0; f3 < 8; f3++) begin
      if (f3 == 2 || f3 == 3) begin
        continue;
      end
      for (int pair = 0; pair < 3; pair++) begin
        ra = (pair == 0) ? 5'd7 : (pair == 1) ? 5'd8 : 5'd9;
        rb = (pair == 0) ? 5'd7 : (pair == 1) ? 5'd9 : 5'd8;
        va = (pair == 0) ? a : (pair == 1) ? n : p;
        vb = (pair == 0) ? a : (pair == 1) ? p : n;
        // x6 keeps 1 only when the branch skips the second addi
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd6, rv32_pkg::opc_op_imm));
        emit(b_type(13'd8, rb, ra, 3'(f3)));
        emit(i_type(12'd2, 5'd0, 3'b000, 5'd6, rv32_pkg::opc_op_imm));
        store_result(5'd6, branch_expect(3'(f3), va, vb) ? 32'd1 : 32'd2);
      end
    end
    emit(i_type(12'd3, 5'd0, 3'b000, 5'd6, rv32_pkg::opc_op_imm));
    here = 32'(prog_idx * 4);
    emit(j_type(21'd8, 5'd10));
    emit(i_type(12'd4, 5'd0, 3'b000, 5'd6, rv32_pkg::opc_op_imm));
    store_result(5'd6, 32'd3);
    store_result(5'd10, here + 32'd4);
    // jalr base is odd after the offset, bit zero must be dropped
    here = 32'(prog_idx * 4);
    load_imm(5'd11, here + 32'd20);
    emit(i_type(12'd5, 5'd0, 3'b000, 5'd6, rv32_pkg::opc_op_imm));
    emit(i_type(12'd1, 5'd11, 3'b000, 5'd12, rv32_pkg::opc_jalr));
    emit(i_type(12'd6, 5'd0, 3'b000, 5'd6, rv32_pkg::opc_op_imm));
    store_result(5'd6, 32'd5);
    store_result(5'd12, here + 32'd16);
    end_program();
    run_until_done(name);
    compare_results(name);
  endtask

  task automatic load_back(input logic [2:0] f3, input int off, input logic [31:0] w);
    emit(i_type(12'(32 + off), 5'd13, f3, 5'd15, rv32_pkg::opc_load));
    store_result(5'd15, load_expect(f3, off, w));
  endtask

  task automatic sized_access_test(input string name);
    logic [31:0] v;
    logic [31:0] w;
    logic [31:0] exp;
    begin_program(name);
    v = $urandom();
    // byte 0 and the upper half negative, byte 1 and the lower half positive
    w = ($urandom() & 32'h7fff_7f7f) | 32'h8000_0080;
    mem[data_idx + 8] = w;
    emit(i_type(12'h400, 5'd1, 3'b000, 5'd13, rv32_pkg::opc_op_imm));
    load_imm(5'd14, v);
    for (int o = 0; o < 4; o++) begin
      emit(s_type(12'(5 * o), 5'd14, 5'd13, 3'b000));
    end
    emit(s_type(12'd16, 5'd14, 5'd13, 3'b001));
    emit(s_type(12'd22, 5'd14, 5'd13, 3'b001));
    for (int o = 0; o < 4; o++) begin
      load_back(3'b000, o, w);
      load_back(3'b100, o, w);
      if (o % 2 == 0) begin
        load_back(3'b001, o, w);
        load_back(3'b101, o, w);
      end
    end
    load_back(3'b010, 0, w);
    end_program();
    run_until_done(name);
    compare_results(name);
    for (int o = 0; o < 4; o++) begin
      exp = fill_word(data_idx + o);
      exp[8*o +: 8] = v[7:0];
      compare_word(name, data_idx + o, exp);
    end
    exp = fill_word(data_idx + 4);
    exp[15:0] = v[15:0];
    compare_word(name, data_idx + 4, exp);
    exp = fill_word(data_idx + 5);
    exp[31:16] = v[15:0];
    compare_word(name, data_idx + 5, exp);
  endtask

  task automatic trap_test(input string name, input int fault);
    logic [31:0] mark;
    begin_program(name);
    mark = $urandom();
    load_imm(5'd15, mark);
    store_result(5'd15, mark);
    case (fault)
      0: emit(i_type(12'h402, 5'd1, 3'b010, 5'd16, rv32_pkg::opc_load));
      1: emit(32'h0000_0073);
      default: begin
        load_imm(5'd17, 32'h0000_0100);
        emit(i_type(12'h002, 5'd17, 3'b000, 5'd0, rv32_pkg::opc_jalr));
      end
    endcase
    emit(s_type(12'h004, 5'd15, 5'd1, 3'b010));
    end_program();
    release_reset();
    while (!trap && mem[done_idx] !== done_value) begin
      @(negedge clk);
    end
    if (!trap) begin
      errors++;
      $display("%s: trap did not rise", name);
    end else begin
      repeat (16) begin
        @(negedge clk);
        if (mem_req.valid) begin
          errors++;
          $display("%s: memory request issued after trap", name);
        end
        if (!trap) begin
          errors++;
          $display("%s: trap fell before reset", name);
        end
      end
    end
    compare_results(name);
    compare_word(name, result_idx + 1, fill_word(result_idx + 1));
    compare_word(name, done_idx, fill_word(done_idx));
  endtask

  initial begin
    void'($urandom(32'hadd2ed71));
    clk = 1'b0;
    reset = 1'b1;
    mem_rsp = '0;
    max_wait = 0;
    wait_left = 0;
    busy = 1'b0;
    cycles = 0;
    checks = 0;
    errors = 0;
    test_name = "";
    alu_ops_test("alu_ops", 2);
    control_flow_test("control_flow");
    sized_access_test("sized_access");
    trap_test("trap_misaligned_load", 0);
    trap_test("trap_illegal_word", 1);
    trap_test("trap_jalr_target", 2);
    max_wait = 3;
    alu_ops_test("back_pressure", 2);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv32_core.f
verilog/rv32_pkg.sv
verilog/rv32_decoder.sv
verilog/rv32_regfile.sv
verilog/rv32_alu.sv
verilog/rv32_lsu.sv
verilog/rv32_control.sv
verilog/rv32_core.sv
dv/rv32_core_chk.sv
dv/rv32_core_tb.sv

//--- verilog/rv32_alu.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_alu (
  input  rv32_pkg::alu_op_e op,
  input  rv32_pkg::branch_e branch,
  input  rv32_pkg::word_t   a,
  input  rv32_pkg::word_t   b,
  output rv32_pkg::word_t   result,
  output logic              taken
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv32_pkg::alu_add:  result = a + b;
      rv32_pkg::alu_sub:  result = a - b;
      rv32_pkg::alu_sll:  result = a << shamt;
      rv32_pkg::alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
      rv32_pkg::alu_sltu: result = {31'b0, a < b};
      rv32_pkg::alu_xor:  result = a ^ b;
      rv32_pkg::alu_srl:  result = a >> shamt;
      rv32_pkg::alu_sra:  result = $signed(a) >>> shamt;
      rv32_pkg::alu_or:   result = a | b;
      rv32_pkg::alu_and:  result = a & b;
      default:            result = b;
    endcase
  end

  // branch compare works on the register operands
  always_comb begin
    case (branch)
      rv32_pkg::br_eq:  taken = a == b;
      rv32_pkg::br_ne:  taken = a != b;
      rv32_pkg::br_lt:  taken = $signed(a) < $signed(b);
      rv32_pkg::br_ge:  taken = $signed(a) >= $signed(b);
      rv32_pkg::br_ltu: taken = a < b;
      rv32_pkg::br_geu: taken = a >= b;
      default:          taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/rv32_control.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_control #(
  parameter rv32_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  logic               clk,
  input  logic               reset,
  input  rv32_pkg::decoded_t dec,
  input  rv32_pkg::word_t    rs1_data,
  input  rv32_pkg::word_t    rs2_data,
  input  rv32_pkg::word_t    alu_result,
  input  logic               taken,
  input  rv32_pkg::word_t    lsu_addr,
  input  logic [3:0]         lsu_wstrb,
  input  rv32_pkg::word_t    lsu_wdata,
  input  logic               misaligned,
  input  rv32_pkg::word_t    load_data,
  input  rv32_pkg::mem_rsp_t mem_rsp,
  output rv32_pkg::mem_req_t mem_req,
  output rv32_pkg::instr_t   instr,
  output rv32_pkg::word_t    pc,
  output rv32_pkg::word_t    alu_a,
  output rv32_pkg::word_t    alu_b,
  output logic               rf_we,
  output rv32_pkg::word_t    rf_wdata,
  output logic               trap
);

  typedef enum logic [2:0] {
    st_fetch, st_wait_instr, st_execute, st_mem_wait, st_check_pc, st_write_back, st_trap
  } state_e;

  state_e             state;
  rv32_pkg::mem_req_t req_q;
  rv32_pkg::word_t    next_pc;
  rv32_pkg::word_t    target;
  rv32_pkg::word_t    wb_data;
  rv32_pkg::word_t    pc_plus4;
  logic               trap_q;

  assign pc_plus4 = pc + 32'd4;

  assign alu_a = dec.use_pc ? pc : rs1_data;
  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  assign rf_we    = state == st_write_back;
  assign rf_wdata = wb_data;
  assign mem_req  = req_q;
  assign trap     = trap_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_fetch;
      pc          <= reset_pc;
      next_pc     <= reset_pc;
      req_q.valid <= 1'b0;
      trap_q      <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          req_q.valid <= 1'b1;
          req_q.instr <= 1'b1;
          req_q.addr  <= next_pc;
          req_q.wstrb <= 4'b0000;
          state       <= st_wait_instr;
        end
        st_wait_instr: begin
          if (mem_rsp.ready) begin
            req_q.valid <= 1'b0;
            pc          <= req_q.addr;
            instr       <= rv32_pkg::instr_t'(mem_rsp.rdata);
            state       <= st_execute;
          end
        end
        st_execute: begin
          // anything not taking the alu path commits its next pc in check_pc
          target <= pc_plus4;
          case (dec.kind)
            rv32_pkg::kind_alu: begin
              wb_data <= alu_result;
              next_pc <= pc_plus4;
              state   <= st_write_back;
            end
            rv32_pkg::kind_jal: begin
              wb_data <= pc_plus4;
              target  <= pc + dec.imm;
              state   <= st_check_pc;
            end
            rv32_pkg::kind_jalr: begin
              wb_data <= pc_plus4;
              target  <= {alu_result[31:1], 1'b0};
              state   <= st_check_pc;
            end
            rv32_pkg::kind_branch: begin
              target <= taken ? pc + dec.imm : pc_plus4;
              state  <= st_check_pc;
            end
            rv32_pkg::kind_load, rv32_pkg::kind_store: begin
              if (misaligned) begin
                trap_q <= 1'b1;
                state  <= st_trap;
              end else begin
                req_q.valid <= 1'b1;
                req_q.instr <= 1'b0;
                req_q.addr  <= lsu_addr;
                req_q.wdata <= lsu_wdata;
                req_q.wstrb <= (dec.kind == rv32_pkg::kind_store) ? lsu_wstrb : 4'b0000;
                state       <= st_mem_wait;
              end
            end
            default: begin
              trap_q <= 1'b1;
              state  <= st_trap;
            end
          endcase
        end
        st_mem_wait: begin
          if (mem_rsp.ready) begin
            req_q.valid <= 1'b0;
            wb_data     <= load_data;
            state       <= st_check_pc;
          end
        end
        st_check_pc: begin
          if (target[1:0] != 2'b00) begin
            trap_q <= 1'b1;
            state  <= st_trap;
          end else begin
            next_pc <= target;
            if (dec.kind == rv32_pkg::kind_branch || dec.kind == rv32_pkg::kind_store) begin
              state <= st_fetch;
            end else begin
              state <= st_write_back;
            end
          end
        end
        st_write_back: begin
          state <= st_fetch;
        end
        default: begin
          // halted until reset
          trap_q <= 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/rv32_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_core #(
  parameter rv32_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  logic               clk,
  input  logic               reset,
  output rv32_pkg::mem_req_t mem_req,
  input  rv32_pkg::mem_rsp_t mem_rsp,
  output logic               trap
);

  rv32_pkg::instr_t   instr;
  rv32_pkg::decoded_t dec;
  rv32_pkg::word_t    pc;
  rv32_pkg::word_t    rs1_data;
  rv32_pkg::word_t    rs2_data;
  rv32_pkg::word_t    alu_a;
  rv32_pkg::word_t    alu_b;
  rv32_pkg::word_t    alu_result;
  logic               taken;
  rv32_pkg::word_t    lsu_addr;
  logic [3:0]         lsu_wstrb;
  rv32_pkg::word_t    lsu_wdata;
  logic               misaligned;
  rv32_pkg::word_t    load_data;
  logic               rf_we;
  rv32_pkg::word_t    rf_wdata;

  rv32_control #(
    .reset_pc(reset_pc)
  ) i_control (
    .clk       (clk),
    .reset     (reset),
    .dec       (dec),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .alu_result(alu_result),
    .taken     (taken),
    .lsu_addr  (lsu_addr),
    .lsu_wstrb (lsu_wstrb),
    .lsu_wdata (lsu_wdata),
    .misaligned(misaligned),
    .load_data (load_data),
    .mem_rsp   (mem_rsp),
    .mem_req   (mem_req),
    .instr     (instr),
    .pc        (pc),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .rf_we     (rf_we),
    .rf_wdata  (rf_wdata),
    .trap      (trap)
  );

  rv32_decoder i_decoder (
    .instr(instr),
    .dec  (dec)
  );

  rv32_regfile i_regfile (
    .clk     (clk),
    .we      (rf_we),
    .waddr   (dec.rd),
    .wdata   (rf_wdata),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  rv32_alu i_alu (
    .op    (dec.alu_op),
    .branch(dec.branch),
    .a     (alu_a),
    .b     (alu_b),
    .result(alu_result),
    .taken (taken)
  );

  rv32_lsu i_lsu (
    .dec       (dec),
    .base      (rs1_data),
    .store_data(rs2_data),
    .rdata     (mem_rsp.rdata),
    .addr      (lsu_addr),
    .wstrb     (lsu_wstrb),
    .wdata     (lsu_wdata),
    .misaligned(misaligned),
    .load_data (load_data)
  );

endmodule

`default_nettype wire

//--- verilog/rv32_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_decoder (
  input  rv32_pkg::instr_t   instr,
  output rv32_pkg::decoded_t dec
);

  logic [6:0]        funct7;
  logic [2:0]        funct3;
  logic              reg_form;
  logic              alu_legal;
  rv32_pkg::alu_op_e alu_op;
  rv32_pkg::word_t   imm_i;
  rv32_pkg::word_t   imm_s;
  rv32_pkg::word_t   imm_b;
  rv32_pkg::word_t   imm_u;
  rv32_pkg::word_t   imm_j;

  assign funct7   = instr.r.funct7;
  assign funct3   = instr.r.funct3;
  assign reg_form = instr.r.opcode == rv32_pkg::opc_op;

  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{20{funct7[6]}}, funct7, instr.r.rd};
  assign imm_b = {{20{funct7[6]}}, instr.r.rd[0], funct7[5:0], instr.r.rd[4:1], 1'b0};
  assign imm_u = {funct7, instr.r.rs2, instr.r.rs1, funct3, 12'h000};
  assign imm_j = {{12{funct7[6]}}, instr.r.rs1, funct3, instr.r.rs2[0],
                  funct7[5:0], instr.r.rs2[4:1], 1'b0};

  // only sub, sra and srai may use a nonzero funct7
  always_comb begin
    if (reg_form) begin
      alu_legal = funct7 == 7'h00 ||
                  (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
    end else if (funct3 == 3'b001) begin
      alu_legal = funct7 == 7'h00;
    end else if (funct3 == 3'b101) begin
      alu_legal = funct7 == 7'h00 || funct7 == 7'h20;
    end else begin
      alu_legal = 1'b1;
    end
  end

  always_comb begin
    case (funct3)
      3'b000:  alu_op = (reg_form && funct7[5]) ? rv32_pkg::alu_sub : rv32_pkg::alu_add;
      3'b001:  alu_op = rv32_pkg::alu_sll;
      3'b010:  alu_op = rv32_pkg::alu_slt;
      3'b011:  alu_op = rv32_pkg::alu_sltu;
      3'b100:  alu_op = rv32_pkg::alu_xor;
      3'b101:  alu_op = funct7[5] ? rv32_pkg::alu_sra : rv32_pkg::alu_srl;
      3'b110:  alu_op = rv32_pkg::alu_or;
      default: alu_op = rv32_pkg::alu_and;
    endcase
  end

  always_comb begin
    dec              = '0;
    dec.kind         = rv32_pkg::kind_illegal;
    dec.rd           = instr.r.rd;
    dec.rs1          = instr.r.rs1;
    dec.rs2          = instr.r.rs2;
    dec.alu_op       = rv32_pkg::alu_add;
    dec.branch       = rv32_pkg::branch_e'(funct3);
    dec.mem_size     = rv32_pkg::mem_size_e'(funct3[1:0]);
    dec.mem_unsigned = funct3[2];
    // compressed words never match, their low bits are not 2'b11
    case (instr.r.opcode)
      rv32_pkg::opc_lui: begin
        dec.kind    = rv32_pkg::kind_alu;
        dec.alu_op  = rv32_pkg::alu_pass_b;
        dec.use_imm = 1'b1;
        dec.imm     = imm_u;
      end
      rv32_pkg::opc_auipc: begin
        dec.kind    = rv32_pkg::kind_alu;
        dec.use_pc  = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = imm_u;
      end
      rv32_pkg::opc_jal: begin
        dec.kind = rv32_pkg::kind_jal;
        dec.imm  = imm_j;
      end
      rv32_pkg::opc_jalr: begin
        if (funct3 == 3'b000) begin
          dec.kind = rv32_pkg::kind_jalr;
        end
        dec.use_imm = 1'b1;
        dec.imm     = imm_i;
      end
      rv32_pkg::opc_branch: begin
        if (funct3[2:1] != 2'b01) begin
          dec.kind = rv32_pkg::kind_branch;
        end
        dec.imm = imm_b;
      end
      rv32_pkg::opc_load: begin
        if (funct3[1:0] != 2'b11 && funct3[2:1] != 2'b11) begin
          dec.kind = rv32_pkg::kind_load;
        end
        dec.imm = imm_i;
      end
      rv32_pkg::opc_store: begin
        if (!funct3[2] && funct3[1:0] != 2'b11) begin
          dec.kind = rv32_pkg::kind_store;
        end
        dec.imm = imm_s;
      end
      rv32_pkg::opc_op_imm, rv32_pkg::opc_op: begin
        if (alu_legal) begin
          dec.kind = rv32_pkg::kind_alu;
        end
        dec.alu_op  = alu_op;
        dec.use_imm = !reg_form;
        dec.imm     = imm_i;
      end
      default: begin
        dec.kind = rv32_pkg::kind_illegal;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/rv32_lsu.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_lsu (
  input  rv32_pkg::decoded_t dec,
  input  rv32_pkg::word_t    base,
  input  rv32_pkg::word_t    store_data,
  input  rv32_pkg::word_t    rdata,
  output rv32_pkg::word_t    addr,
  output logic [3:0]         wstrb,
  output rv32_pkg::word_t    wdata,
  output logic               misaligned,
  output rv32_pkg::word_t    load_data
);

  rv32_pkg::word_t ea;
  logic [7:0]      lane_b;
  logic [15:0]     lane_h;

  assign ea   = base + dec.imm;
  assign addr = {ea[31:2], 2'b00};

  assign misaligned = (dec.mem_size == rv32_pkg::size_half && ea[0]) ||
                      (dec.mem_size == rv32_pkg::size_word && ea[1:0] != 2'b00);

  // data is replicated so any enabled lane carries it
  always_comb begin
    case (dec.mem_size)
      rv32_pkg::size_byte: begin
        wstrb = 4'b0001 << ea[1:0];
        wdata = {4{store_data[7:0]}};
      end
      rv32_pkg::size_half: begin
        wstrb = ea[1] ? 4'b1100 : 4'b0011;
        wdata = {2{store_data[15:0]}};
      end
      default: begin
        wstrb = 4'b1111;
        wdata = store_data;
      end
    endcase
  end

  assign lane_b = rdata[ea[1:0]*8 +: 8];
  assign lane_h = ea[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (dec.mem_size)
      rv32_pkg::size_byte: begin
        load_data = {{24{lane_b[7] & !dec.mem_unsigned}}, lane_b};
      end
      rv32_pkg::size_half: begin
        load_data = {{16{lane_h[15] & !dec.mem_unsigned}}, lane_h};
      end
      default: begin
        load_data = rdata;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  // values follow funct3 of the branch opcode
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } branch_e;

  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

  typedef enum logic [2:0] {
    kind_alu, kind_branch, kind_jal, kind_jalr, kind_load, kind_store, kind_illegal
  } kind_e;

  typedef struct packed {
    kind_e     kind;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      use_pc;
    branch_e   branch;
    mem_size_e mem_size;
    logic      mem_unsigned;
    word_t     imm;
  } decoded_t;

  typedef struct packed {
    logic       valid;
    logic       instr;
    word_t      addr;
    word_t      wdata;
    logic [3:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- verilog/rv32_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_regfile (
  input  logic                clk,
  input  logic                we,
  input  rv32_pkg::reg_addr_t waddr,
  input  rv32_pkg::word_t     wdata,
  input  rv32_pkg::reg_addr_t rs1,
  input  rv32_pkg::reg_addr_t rs2,
  output rv32_pkg::word_t     rs1_data,
  output rv32_pkg::word_t     rs2_data
);

  rv32_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is never written, so its entry is masked on read
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire
